// File: src.f
hdl/dualIssuePkg.sv
hdl/issueSplit.sv
hdl/issueLane.sv
hdl/resultForward.sv
hdl/registerFile.sv
hdl/dualIssueCore.sv
tb/dualIssueTb.sv

// File: Makefile
SRCS := $(wildcard hdl/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: obj_dir/VdualIssueTb

obj_dir/VdualIssueTb: src.f $(SRCS)
	verilator --binary --timing --assert --top-module dualIssueTb -f src.f -o VdualIssueTb

run: obj_dir/VdualIssueTb
	./obj_dir/VdualIssueTb

clean:
	rm -rf obj_dir

// File: tb/dualIssueTb.sv
`default_nettype none

module dualIssueTb;

    localparam int numDirected  = 16;
    localparam int numRandom    = 300;
    localparam int numPairs     = numDirected + numRandom;
    localparam int seed         = 69238;
    localparam int resetCycles  = 5;
    localparam int watchdogCycles = numPairs * 2 + 50 + resetCycles;

    logic        clk;
    logic        rstN;
    logic [31:0] instr1;
    logic [31:0] instr2;
    logic        pairValid;
    logic        pairReady;
    logic        commitValid1;
    logic        commitValid2;
    logic [4:0]  commitReg1;
    logic [4:0]  commitReg2;
    logic [31:0] commitData1;
    logic [31:0] commitData2;

    // reference model state
    logic [31:0] model [32];
    logic        pending;
    logic        accepted;
    logic        expReady;
    logic        e1Valid;
    logic        e2Valid;
    logic        w1Valid;
    logic        w2Valid;
    logic [4:0]  e1Reg;
    logic [4:0]  e2Reg;
    logic [4:0]  w1Reg;
    logic [4:0]  w2Reg;
    logic [31:0] e1Data;
    logic [31:0] e2Data;
    logic [31:0] w1Data;
    logic [31:0] w2Data;
    logic        issue1;
    logic        issue2;
    logic        acc;
    logic        v1;
    logic        v2;
    logic [4:0]  d1;
    logic [4:0]  d2;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] pairQ1 [$];
    logic [31:0] pairQ2 [$];

    dualIssueCore dualIssueCore_inst (
        .clk(clk), .rstN(rstN), .instr1(instr1), .instr2(instr2), .pairValid(pairValid),
        .pairReady(pairReady), .commitValid1(commitValid1), .commitValid2(commitValid2),
        .commitReg1(commitReg1), .commitReg2(commitReg2),
        .commitData1(commitData1), .commitData2(commitData2)
    );

    function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                          input int shamt, input int fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn[5:0]};
    endfunction

    function automatic logic [31:0] iType(input int op, input int rs, input int rt,
                                          input int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic knownOp(input logic [31:0] ins);
        if (ins[31:26] == 6'h00) begin
            return ins[5:0] inside {6'h00, 6'h02, 6'h20, 6'h22, 6'h24, 6'h25, 6'h2a};
        end
        return ins[31:26] inside {6'h08, 6'h0c, 6'h0d};
    endfunction

    // rd for R-type, rt for immediates
    function automatic logic [4:0] destOf(input logic [31:0] ins);
        return (ins[31:26] == 6'h00) ? ins[15:11] : ins[20:16];
    endfunction

    function automatic logic writesReg(input logic [31:0] ins);
        return knownOp(ins) && (destOf(ins) != 5'd0);
    endfunction

    function automatic logic pairNeedsSplit(input logic [31:0] a, input logic [31:0] b);
        return writesReg(a) && ((b[25:21] == destOf(a)) ||
               ((b[31:26] == 6'h00) && (b[20:16] == destOf(a))));
    endfunction

    function automatic logic [31:0] aluResult(input logic [31:0] ins, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] imm;
        imm = {{16{ins[15]}}, ins[15:0]};
        case (ins[31:26])
            6'h00: begin
                case (ins[5:0])
                    6'h20: return a + b;
                    6'h22: return a - b;
                    6'h24: return a & b;
                    6'h25: return a | b;
                    6'h2a: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00: return b << ins[10:6];
                    6'h02: return b >> ins[10:6];
                    default: return 32'd0;
                endcase
            end
            6'h08: return a + imm;
            6'h0c: return a & imm;
            6'h0d: return a | imm;
            default: return 32'd0;
        endcase
    endfunction

    task automatic reportFail(input string msg);
        $display("CHECK FAILED: time %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic addPair(input logic [31:0] a, input logic [31:0] b);
        pairQ1.push_back(a);
        pairQ2.push_back(b);
    endtask

    assign expReady = pending || !(pairValid && pairNeedsSplit(instr1, instr2));

    // model in program order, lane 1 before lane 2, commit two edges after issue
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                model[i] = 32'd0;
            end
            pending  <= 1'b0;
            accepted <= 1'b0;
            e1Valid  <= 1'b0;
            e2Valid  <= 1'b0;
            w1Valid  <= 1'b0;
            w2Valid  <= 1'b0;
        end else begin
            issue1 = 1'b0;
            issue2 = 1'b0;
            acc = 1'b0;
            if (pairValid) begin
                if (pending) begin
                    issue2 = 1'b1;
                    acc = 1'b1;
                end else if (pairNeedsSplit(instr1, instr2)) begin
                    issue1 = 1'b1;
                end else begin
                    issue1 = 1'b1;
                    issue2 = 1'b1;
                    acc = 1'b1;
                end
            end
            v1 = issue1 && writesReg(instr1);
            d1 = destOf(instr1);
            r1 = aluResult(instr1, model[instr1[25:21]], model[instr1[20:16]]);
            if (v1) begin
                model[d1] = r1;
            end
            v2 = issue2 && writesReg(instr2);
            d2 = destOf(instr2);
            r2 = aluResult(instr2, model[instr2[25:21]], model[instr2[20:16]]);
            if (v2) begin
                model[d2] = r2;
            end
            // lane 2 keeps a destination shared within one pair
            if (v1 && v2 && d1 == d2) begin
                v1 = 1'b0;
            end
            pending  <= pairValid && !pending && pairNeedsSplit(instr1, instr2);
            accepted <= acc;
            e1Valid <= v1;
            e1Reg   <= d1;
            e1Data  <= r1;
            e2Valid <= v2;
            e2Reg   <= d2;
            e2Data  <= r2;
            w1Valid <= e1Valid;
            w1Reg   <= e1Reg;
            w1Data  <= e1Data;
            w2Valid <= e2Valid;
            w2Reg   <= e2Reg;
            w2Data  <= e2Data;
        end
    end

    readyMatch: assert property (@(posedge clk) disable iff (!rstN) pairReady == expReady)
        else reportFail("pairReady differs from the split rule");
    valid1Match: assert property (@(posedge clk) disable iff (!rstN) commitValid1 == w1Valid)
        else reportFail("commitValid1 differs from model");
    valid2Match: assert property (@(posedge clk) disable iff (!rstN) commitValid2 == w2Valid)
        else reportFail("commitValid2 differs from model");
    commit1Match: assert property (@(posedge clk) disable iff (!rstN)
        commitValid1 |-> (commitReg1 == w1Reg && commitData1 == w1Data))
        else reportFail("lane 1 commit register or data wrong");
    commit2Match: assert property (@(posedge clk) disable iff (!rstN)
        commitValid2 |-> (commitReg2 == w2Reg && commitData2 == w2Data))
        else reportFail("lane 2 commit register or data wrong");

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog: the run did not finish in %0d cycles", watchdogCycles);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        int op;
        rstN = 1'b0;
        instr1 = 32'd0;
        instr2 = 32'd0;
        pairValid = 1'b0;
        void'($urandom(seed));
        addPair(iType(8, 0, 1, 5), iType(8, 0, 2, 'hfffd));
        addPair(rType(1, 2, 3, 0, 'h20), rType(1, 2, 4, 0, 'h22));
        addPair(rType(2, 1, 5, 0, 'h2a), rType(0, 1, 6, 4, 'h00));
        addPair(rType(0, 2, 7, 3, 'h02), iType('h0c, 2, 8, 'h00f0));
        // r5 from two pairs back and r0 reading zero
        addPair(iType('h0d, 1, 9, 'h8001), rType(0, 5, 13, 0, 'h25));
        addPair(iType(8, 0, 10, 'h100), rType(10, 6, 11, 0, 'h20));
        addPair(iType(8, 0, 12, 7), iType(8, 0, 12, 9));
        addPair(rType(12, 0, 16, 0, 'h20), iType(8, 1, 0, 3));
        addPair({6'h3f, 26'h0123456}, rType(1, 2, 3, 0, 'h3f));
        addPair(rType(12, 5, 17, 0, 'h22), rType(1, 2, 18, 0, 'h2a));
        addPair(rType(0, 2, 19, 31, 'h00), rType(0, 2, 20, 1, 'h02));
        addPair(iType('h0c, 9, 21, 'hff00), iType('h0d, 0, 22, 'h7fff));
        addPair(rType(3, 3, 3, 0, 'h20), rType(3, 3, 3, 0, 'h20));
        addPair(iType(8, 3, 23, 'hffff), rType(0, 3, 24, 0, 'h22));
        addPair(rType(24, 0, 25, 0, 'h2a), rType(25, 23, 26, 0, 'h20));
        addPair(rType(26, 0, 27, 0, 'h25), rType(27, 26, 28, 0, 'h24));
        // small register pool keeps dependencies frequent
        for (int i = 0; i < 2 * numRandom; i++) begin
            op = $urandom_range(0, 11);
            case (op)
                0: pairQ1.push_back(rType($urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 7), 0, 'h20));
                1: pairQ1.push_back(rType($urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 7), 0, 'h22));
                2: pairQ1.push_back(rType($urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 7), 0, 'h24));
                3: pairQ1.push_back(rType($urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 7), 0, 'h25));
                4: pairQ1.push_back(rType($urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 7), 0, 'h2a));
                5: pairQ1.push_back(rType(0, $urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 31), 'h00));
                6: pairQ1.push_back(rType(0, $urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 31), 'h02));
                7: pairQ1.push_back(iType(8, $urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 'hffff)));
                8: pairQ1.push_back(iType('h0c, $urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 'hffff)));
                9: pairQ1.push_back(iType('h0d, $urandom_range(0, 7), $urandom_range(0, 7),
                        $urandom_range(0, 'hffff)));
                default: pairQ1.push_back($urandom);
            endcase
        end
        for (int i = 0; i < numRandom; i++) begin
            pairQ2.push_back(pairQ1[numDirected + 2 * i + 1]);
            pairQ1[numDirected + i] = pairQ1[numDirected + 2 * i];
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        // pairs go back to back so the E stage of the previous pair feeds the next
        for (int p = 0; p < numPairs; p++) begin
            instr1 = pairQ1[p];
            instr2 = pairQ2[p];
            pairValid = 1'b1;
            // hold the pair until the model sees it accepted
            do begin
                @(negedge clk);
            end while (!accepted);
        end
        pairValid = 1'b0;
        repeat (4) @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/dualIssueCore.sv
`default_nettype none

module dualIssueCore (
    input  wire logic                                  clk,
    input  wire logic                                  rstN,
    input  wire logic [dualIssuePkg::instrWidth-1:0]   instr1,
    input  wire logic [dualIssuePkg::instrWidth-1:0]   instr2,
    input  wire logic                                  pairValid,
    output logic                                       pairReady,
    output logic                                       commitValid1,
    output logic                                       commitValid2,
    output logic [dualIssuePkg::regAddrWidth-1:0]      commitReg1,
    output logic [dualIssuePkg::regAddrWidth-1:0]      commitReg2,
    output logic [dualIssuePkg::dataWidth-1:0]         commitData1,
    output logic [dualIssuePkg::dataWidth-1:0]         commitData2
);
    import dualIssuePkg::*;

    logic [instrWidth-1:0]   laneInstr1;
    logic [instrWidth-1:0]   laneInstr2;
    logic                    laneIssue1;
    logic                    laneIssue2;
    logic [regAddrWidth-1:0] readAddrA1;
    logic [regAddrWidth-1:0] readAddrB1;
    logic [regAddrWidth-1:0] readAddrA2;
    logic [regAddrWidth-1:0] readAddrB2;
    logic [dataWidth-1:0]    regDataA1;
    logic [dataWidth-1:0]    regDataB1;
    logic [dataWidth-1:0]    regDataA2;
    logic [dataWidth-1:0]    regDataB2;
    fwdSelT                  fwdSelA1;
    fwdSelT                  fwdSelB1;
    fwdSelT                  fwdSelA2;
    fwdSelT                  fwdSelB2;
    logic [regAddrWidth-1:0] destE1;
    logic [regAddrWidth-1:0] destE2;
    logic                    writeE1;
    logic                    writeE2;
    logic [dataWidth-1:0]    resultE1;
    logic [dataWidth-1:0]    resultE2;
    logic                    writeW1;
    logic                    writeW2;

    issueSplit issueSplit_inst (
        .clk(clk), .rstN(rstN), .instr1(instr1), .instr2(instr2), .pairValid(pairValid),
        .pairReady(pairReady), .laneInstr1(laneInstr1), .laneInstr2(laneInstr2),
        .laneIssue1(laneIssue1), .laneIssue2(laneIssue2)
    );

    // W stage of each lane drives the commit ports directly
    issueLane lane1_inst (
        .clk(clk), .rstN(rstN), .laneInstr(laneInstr1), .laneIssue(laneIssue1),
        .regDataA(regDataA1), .regDataB(regDataB1), .fwdSelA(fwdSelA1), .fwdSelB(fwdSelB1),
        .resultE1(resultE1), .resultE2(resultE2), .resultW1(commitData1), .resultW2(commitData2),
        .readAddrA(readAddrA1), .readAddrB(readAddrB1), .destE(destE1), .writeE(writeE1),
        .resultE(resultE1), .destW(commitReg1), .writeW(writeW1), .resultW(commitData1)
    );

    issueLane lane2_inst (
        .clk(clk), .rstN(rstN), .laneInstr(laneInstr2), .laneIssue(laneIssue2),
        .regDataA(regDataA2), .regDataB(regDataB2), .fwdSelA(fwdSelA2), .fwdSelB(fwdSelB2),
        .resultE1(resultE1), .resultE2(resultE2), .resultW1(commitData1), .resultW2(commitData2),
        .readAddrA(readAddrA2), .readAddrB(readAddrB2), .destE(destE2), .writeE(writeE2),
        .resultE(resultE2), .destW(commitReg2), .writeW(writeW2), .resultW(commitData2)
    );

    resultForward resultForward_inst (
        .readAddrA1(readAddrA1), .readAddrB1(readAddrB1),
        .readAddrA2(readAddrA2), .readAddrB2(readAddrB2),
        .destE1(destE1), .writeE1(writeE1), .destE2(destE2), .writeE2(writeE2),
        .destW1(commitReg1), .writeW1(writeW1), .destW2(commitReg2), .writeW2(writeW2),
        .fwdSelA1(fwdSelA1), .fwdSelB1(fwdSelB1), .fwdSelA2(fwdSelA2), .fwdSelB2(fwdSelB2),
        .wrEn1(commitValid1), .wrEn2(commitValid2)
    );

    registerFile registerFile_inst (
        .clk(clk), .rstN(rstN),
        .readAddr1(readAddrA1), .readAddr2(readAddrB1),
        .readAddr3(readAddrA2), .readAddr4(readAddrB2),
        .wrEn1(commitValid1), .wrAddr1(commitReg1), .wrData1(commitData1),
        .wrEn2(commitValid2), .wrAddr2(commitReg2), .wrData2(commitData2),
        .readData1(regDataA1), .readData2(regDataB1),
        .readData3(regDataA2), .readData4(regDataB2)
    );

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`default_nettype none

module registerFile (
    input  wire logic                                  clk,
    input  wire logic                                  rstN,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] readAddr1,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] readAddr2,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] readAddr3,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] readAddr4,
    input  wire logic                                  wrEn1,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] wrAddr1,
    input  wire logic [dualIssuePkg::dataWidth-1:0]    wrData1,
    input  wire logic                                  wrEn2,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] wrAddr2,
    input  wire logic [dualIssuePkg::dataWidth-1:0]    wrData2,
    output logic [dualIssuePkg::dataWidth-1:0]         readData1,
    output logic [dualIssuePkg::dataWidth-1:0]         readData2,
    output logic [dualIssuePkg::dataWidth-1:0]         readData3,
    output logic [dualIssuePkg::dataWidth-1:0]         readData4
);
    import dualIssuePkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_comb begin
        readData1 = readReg(readAddr1);
        readData2 = readReg(readAddr2);
        readData3 = readReg(readAddr3);
        readData4 = readReg(readAddr4);
    end

    // write priority is settled in resultForward
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrEn1 && wrAddr1 != '0) begin
                regs[wrAddr1] <= wrData1;
            end
            if (wrEn2 && wrAddr2 != '0) begin
                regs[wrAddr2] <= wrData2;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/resultForward.sv
`default_nettype none

module resultForward (
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] readAddrA1,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] readAddrB1,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] readAddrA2,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] readAddrB2,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] destE1,
    input  wire logic                                  writeE1,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] destE2,
    input  wire logic                                  writeE2,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] destW1,
    input  wire logic                                  writeW1,
    input  wire logic [dualIssuePkg::regAddrWidth-1:0] destW2,
    input  wire logic                                  writeW2,
    output dualIssuePkg::fwdSelT                       fwdSelA1,
    output dualIssuePkg::fwdSelT                       fwdSelB1,
    output dualIssuePkg::fwdSelT                       fwdSelA2,
    output dualIssuePkg::fwdSelT                       fwdSelB2,
    output logic                                       wrEn1,
    output logic                                       wrEn2
);
    import dualIssuePkg::*;

    // newest producer wins, lane 2 is younger than lane 1
    function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] addr);
        if (addr == '0) begin
            return fwdReg;
        end else if (writeE2 && destE2 == addr) begin
            return fwdE2;
        end else if (writeE1 && destE1 == addr) begin
            return fwdE1;
        end else if (writeW2 && destW2 == addr) begin
            return fwdW2;
        end else if (writeW1 && destW1 == addr) begin
            return fwdW1;
        end
        return fwdReg;
    endfunction

    always_comb begin
        fwdSelA1 = pickSource(readAddrA1);
        fwdSelB1 = pickSource(readAddrB1);
        fwdSelA2 = pickSource(readAddrA2);
        fwdSelB2 = pickSource(readAddrB2);
    end

    // same destination in W: lane 2 keeps the write
    assign wrEn2 = writeW2;
    assign wrEn1 = writeW1 && !(writeW2 && destW2 == destW1);

    always_comb begin
        singleWriter: assert final (!(wrEn1 && wrEn2 && destW1 == destW2));
    end

endmodule

`default_nettype wire

// File: hdl/issueLane.sv
`default_nettype none

module issueLane (
    input  wire logic                                  clk,
    input  wire logic                                  rstN,
    input  wire logic [dualIssuePkg::instrWidth-1:0]   laneInstr,
    input  wire logic                                  laneIssue,
    input  wire logic [dualIssuePkg::dataWidth-1:0]    regDataA,
    input  wire logic [dualIssuePkg::dataWidth-1:0]    regDataB,
    input  wire dualIssuePkg::fwdSelT                  fwdSelA,
    input  wire dualIssuePkg::fwdSelT                  fwdSelB,
    input  wire logic [dualIssuePkg::dataWidth-1:0]    resultE1,
    input  wire logic [dualIssuePkg::dataWidth-1:0]    resultE2,
    input  wire logic [dualIssuePkg::dataWidth-1:0]    resultW1,
    input  wire logic [dualIssuePkg::dataWidth-1:0]    resultW2,
    output logic [dualIssuePkg::regAddrWidth-1:0]      readAddrA,
    output logic [dualIssuePkg::regAddrWidth-1:0]      readAddrB,
    output logic [dualIssuePkg::regAddrWidth-1:0]      destE,
    output logic                                       writeE,
    output logic [dualIssuePkg::dataWidth-1:0]         resultE,
    output logic [dualIssuePkg::regAddrWidth-1:0]      destW,
    output logic                                       writeW,
    output logic [dualIssuePkg::dataWidth-1:0]         resultW
);
    import dualIssuePkg::*;

    opcodeT                  opcode;
    functT                   funct;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rt;
    logic [dataWidth-1:0]    immExt;
    aluOpT                   aluOpD;
    logic                    useImm;
    logic [regAddrWidth-1:0] destD;
    logic                    writeD;
    logic [dataWidth-1:0]    operandA;
    logic [dataWidth-1:0]    operandB;
    aluOpT                   aluOpE;
    logic [dataWidth-1:0]    operandAE;
    logic [dataWidth-1:0]    operandBE;
    logic [regAddrWidth-1:0] shamtE;

    function automatic logic [dataWidth-1:0] pickOperand(
        input fwdSelT               sel,
        input logic [dataWidth-1:0] regData
    );
        case (sel)
            fwdE1:   return resultE1;
            fwdE2:   return resultE2;
            fwdW1:   return resultW1;
            fwdW2:   return resultW2;
            default: return regData;
        endcase
    endfunction

    assign opcode    = opcodeT'(laneInstr[opMsb:opLsb]);
    assign funct     = functT'(laneInstr[shamtLsb-1:0]);
    assign rd        = laneInstr[rdLsb +: regAddrWidth];
    assign rt        = laneInstr[rtLsb +: regAddrWidth];
    assign readAddrA = laneInstr[rsLsb +: regAddrWidth];
    assign readAddrB = rt;
    assign immExt    = {{(dataWidth-immWidth){laneInstr[immWidth-1]}}, laneInstr[immWidth-1:0]};

    // decode
    always_comb begin
        aluOpD = aluNone;
        useImm = 1'b0;
        destD = rd;
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd:   aluOpD = aluAdd;
                    fnSub:   aluOpD = aluSub;
                    fnAnd:   aluOpD = aluAnd;
                    fnOr:    aluOpD = aluOr;
                    fnSlt:   aluOpD = aluSlt;
                    fnSll:   aluOpD = aluSll;
                    fnSrl:   aluOpD = aluSrl;
                    default: aluOpD = aluNone;
                endcase
            end
            opAddi, opAndi, opOri: begin
                useImm = 1'b1;
                destD = rt;
                if (opcode == opAddi) begin
                    aluOpD = aluAdd;
                end else if (opcode == opAndi) begin
                    aluOpD = aluAnd;
                end else begin
                    aluOpD = aluOr;
                end
            end
            default: aluOpD = aluNone;
        endcase
    end

    // r0 and unknown ops never write
    assign writeD = laneIssue && (aluOpD != aluNone) && (destD != '0);

    always_comb begin
        operandA = pickOperand(fwdSelA, regDataA);
        operandB = pickOperand(fwdSelB, regDataB);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            writeE <= 1'b0;
            writeW <= 1'b0;
        end else begin
            writeE <= writeD;
            writeW <= writeE;
        end
    end

    always_ff @(posedge clk) begin
        aluOpE    <= aluOpD;
        destE     <= destD;
        operandAE <= operandA;
        operandBE <= useImm ? immExt : operandB;
        shamtE    <= laneInstr[shamtLsb +: regAddrWidth];
        destW     <= destE;
        resultW   <= resultE;
    end

    // shifts act on rt, as in MIPS
    always_comb begin
        case (aluOpE)
            aluAdd:  resultE = operandAE + operandBE;
            aluSub:  resultE = operandAE - operandBE;
            aluAnd:  resultE = operandAE & operandBE;
            aluOr:   resultE = operandAE | operandBE;
            aluSlt:  resultE = {{(dataWidth-1){1'b0}}, $signed(operandAE) < $signed(operandBE)};
            aluSll:  resultE = operandBE << shamtE;
            aluSrl:  resultE = operandBE >> shamtE;
            default: resultE = '0;
        endcase
    end

    noWriteToZero: assert property (
        @(posedge clk) disable iff (!rstN) writeW |-> (destW != '0)
    );

endmodule

`default_nettype wire

// File: hdl/issueSplit.sv
`default_nettype none

module issueSplit (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire logic [dualIssuePkg::instrWidth-1:0] instr1,
    input  wire logic [dualIssuePkg::instrWidth-1:0] instr2,
    input  wire logic                              pairValid,
    output logic                                   pairReady,
    output logic [dualIssuePkg::instrWidth-1:0]    laneInstr1,
    output logic [dualIssuePkg::instrWidth-1:0]    laneInstr2,
    output logic                                   laneIssue1,
    output logic                                   laneIssue2
);
    import dualIssuePkg::*;

    opcodeT                  op1;
    opcodeT                  op2;
    functT                   fn1;
    logic [regAddrWidth-1:0] dest1;
    logic                    lane1Writes;
    logic                    needSplit;
    logic                    splitPending;

    assign op1 = opcodeT'(instr1[opMsb:opLsb]);
    assign op2 = opcodeT'(instr2[opMsb:opLsb]);
    assign fn1 = functT'(instr1[shamtLsb-1:0]);

    // lane 1 destination and whether it retires a write at all
    always_comb begin
        lane1Writes = 1'b0;
        dest1 = instr1[rtLsb +: regAddrWidth];
        case (op1)
            opRType: begin
                dest1 = instr1[rdLsb +: regAddrWidth];
                case (fn1)
                    fnSll, fnSrl, fnAdd, fnSub, fnAnd, fnOr, fnSlt: lane1Writes = 1'b1;
                    default: lane1Writes = 1'b0;
                endcase
            end
            opAddi, opAndi, opOri: lane1Writes = 1'b1;
            default: lane1Writes = 1'b0;
        endcase
    end

    // rt only counts as a source for R-type
    assign needSplit = lane1Writes && (dest1 != '0) &&
                       ((instr2[rsLsb +: regAddrWidth] == dest1) ||
                        ((op2 == opRType) && (instr2[rtLsb +: regAddrWidth] == dest1)));

    assign laneInstr1 = instr1;
    assign laneInstr2 = instr2;

    // second cycle of a split sends lane 2 alone
    assign laneIssue1 = pairValid && !splitPending;
    assign laneIssue2 = pairValid && (splitPending || !needSplit);
    assign pairReady  = splitPending || !(pairValid && needSplit);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            splitPending <= 1'b0;
        end else begin
            splitPending <= !splitPending && pairValid && needSplit;
        end
    end

    pendingOneCycle: assert property (
        @(posedge clk) disable iff (!rstN) splitPending |=> !splitPending
    );

endmodule

`default_nettype wire

// File: hdl/dualIssuePkg.sv
`default_nettype none

package dualIssuePkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs      = 32;
    localparam int instrWidth   = 32;

    // MIPS-like field positions
    localparam int opMsb    = 31;
    localparam int opLsb    = 26;
    localparam int rsLsb    = 21;
    localparam int rtLsb    = 16;
    localparam int rdLsb    = 11;
    localparam int shamtLsb = 6;
    localparam int immWidth = 16;

    typedef enum logic [5:0] {
        opRType = 6'h00,
        opAddi  = 6'h08,
        opAndi  = 6'h0c,
        opOri   = 6'h0d
    } opcodeT;

    // funct codes, only meaningful with opRType
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluSrl,
        aluNone
    } aluOpT;

    // operand source, E and W results of both lanes
    typedef enum logic [2:0] {
        fwdReg,
        fwdE1,
        fwdE2,
        fwdW1,
        fwdW2
    } fwdSelT;

endpackage

`default_nettype wire
